// ==== mm_ram.f ====
common/mm_ram_pkg.sv
dp_ram/dp_ram.sv
verilog/mm_timer.sv
verilog/mm_bus_ctrl.sv
verilog/mm_ram.sv
testbench/tb_mm_ram.sv

// ==== Makefile ====
.PHONY: run clean

obj_dir/Vtb_mm_ram: mm_ram.f common/mm_ram_pkg.sv dp_ram/dp_ram.sv verilog/mm_timer.sv \
		verilog/mm_bus_ctrl.sv verilog/mm_ram.sv testbench/tb_mm_ram.sv
	verilator --binary --timing --assert --top-module tb_mm_ram -f mm_ram.f

run: obj_dir/Vtb_mm_ram
	./obj_dir/Vtb_mm_ram

clean:
	rm -rf obj_dir

// ==== testbench/tb_mm_ram.sv ====
`timescale 1ns/100ps

module tb_mm_ram;
  import mm_ram_pkg::*;

  localparam int unsigned ram_addr_width = 16;
  localparam int unsigned instr_width = 128;
  localparam word_t region = 32'h0000_0200;

  typedef logic [instr_width-1:0] line_t;

  // expected data response and the cycle it is due in
  typedef struct packed {
    int    due;
    logic  rd;
    logic  err;
    word_t rdata;
  } data_exp_t;

  typedef struct packed {
    int    due;
    line_t line;
  } instr_exp_t;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      instr_req_i;
  logic [ram_addr_width-1:0] instr_addr_i;
  line_t                     instr_rdata_o;
  logic                      instr_rvalid_o;
  logic                      instr_gnt_o;
  logic                      data_req_i;
  logic                      data_we_i;
  word_t                     data_addr_i;
  word_t                     data_wdata_i;
  be_t                       data_be_i;
  word_t                     data_rdata_o;
  logic                      data_rvalid_o;
  logic                      data_gnt_o;
  logic                      data_err_o;
  irq_id_t                   irq_id_i;
  logic                      irq_ack_i;
  logic                      irq_timer_o;
  logic                      print_valid_o;
  word_t                     print_data_o;
  logic                      tests_passed_o;
  logic                      tests_failed_o;
  logic                      exit_valid_o;
  word_t                     exit_value_o;

  int         cycle = 0;
  logic [7:0] ref_mem [2**ram_addr_width];
  data_exp_t  data_q [$];
  instr_exp_t instr_q [$];

  mm_ram #(
    .ram_addr_width(ram_addr_width),
    .instr_width   (instr_width)
  ) u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic timed_out(input string what);
    $display("timed out while waiting for %s", what);
    stop_run();
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  function automatic word_t expected_word(input word_t addr);
    logic [ram_addr_width-1:0] a;
    word_t w;
    a = {addr[ram_addr_width-1:2], 2'b00};
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = ref_mem[a + ram_addr_width'(b)];
    end
    return w;
  endfunction

  // little-endian line of consecutive words from the aligned word
  function automatic line_t expected_line(input logic [ram_addr_width-1:0] addr);
    logic [ram_addr_width-1:0] a;
    line_t l;
    a = {addr[ram_addr_width-1:2], 2'b00};
    for (int i = 0; i < instr_width / 8; i++) begin
      l[8*i +: 8] = ref_mem[a + ram_addr_width'(i)];
    end
    return l;
  endfunction

  function automatic logic expected_err(input logic we, input word_t addr);
    logic in_ram;
    logic mapped;
    in_ram = addr < (word_t'(1) << ram_addr_width);
    mapped = addr inside {addr_print, addr_status, addr_exit, addr_timer_mask, addr_timer_cnt};
    return !in_ram && (we ? !mapped : addr != addr_timer_read);
  endfunction

  // count after edge at for a count n written at edge wr_edge
  function automatic word_t expected_count(input int n, input int wr_edge, input int at);
    int k;
    k = at - wr_edge;
    return (n > k) ? word_t'(n - k) : '0;
  endfunction

  function automatic int irq_edge(input int n, input int wr_edge);
    return wr_edge + n;
  endfunction

  // one data request with its strobes checked in the request cycle
  task automatic bus_access(input logic we, input word_t addr, input word_t wdata,
                            input be_t be, input word_t exp_rdata);
    data_exp_t                 e;
    logic [3:0]                st;
    logic [ram_addr_width-1:0] a;
    data_req_i = 1'b1;
    data_we_i = we;
    data_addr_i = addr;
    data_wdata_i = wdata;
    data_be_i = be;
    e.due = cycle + 1;
    e.rd = !we;
    e.err = expected_err(we, addr);
    e.rdata = exp_rdata;
    data_q.push_back(e);
    if (we && addr < (word_t'(1) << ram_addr_width)) begin
      a = {addr[ram_addr_width-1:2], 2'b00};
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          ref_mem[a + ram_addr_width'(b)] = wdata[8*b +: 8];
        end
      end
    end
    st = {we && addr == addr_print, we && addr == addr_status && wdata == status_pass_code,
          we && addr == addr_status && wdata == status_fail_code, we && addr == addr_exit};
    @(negedge clk_i);
    check_bit("data_gnt_o", data_gnt_o, 1'b1);
    check_bit("print_valid_o", print_valid_o, st[3]);
    check_bit("tests_passed_o", tests_passed_o, st[2]);
    check_bit("tests_failed_o", tests_failed_o, st[1]);
    check_bit("exit_valid_o", exit_valid_o, st[0]);
    if (st[3]) begin
      check_word("print_data_o", print_data_o, wdata);
    end
    if (st[0]) begin
      check_word("exit_value_o", exit_value_o, wdata);
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic fetch(input logic [ram_addr_width-1:0] addr);
    instr_exp_t e;
    instr_req_i = 1'b1;
    instr_addr_i = addr;
    e.due = cycle + 1;
    e.line = expected_line(addr);
    instr_q.push_back(e);
    @(negedge clk_i);
    check_bit("instr_gnt_o", instr_gnt_o, 1'b1);
    @(posedge clk_i);
    #2;
  endtask

  task automatic go_idle(input int n);
    data_req_i = 1'b0;
    data_we_i = 1'b0;
    instr_req_i = 1'b0;
    irq_ack_i = 1'b0;
    repeat (n) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  // acknowledge held for exactly one edge
  task automatic send_ack(input irq_id_t id);
    irq_id_i = id;
    irq_ack_i = 1'b1;
    @(posedge clk_i);
    #2;
    irq_ack_i = 1'b0;
  endtask

  task automatic wait_irq(input logic level, input int limit, output int at);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > limit) begin
        timed_out("irq_timer_o");
      end
    end while (irq_timer_o !== level);
    at = cycle;
    @(posedge clk_i);
    #2;
  endtask

  // every granted request answers one cycle later
  initial begin
    forever begin
      @(negedge clk_i);
      if (data_q.size() > 0 && data_q[0].due == cycle) begin
        check_bit("data_rvalid_o", data_rvalid_o, 1'b1);
        check_bit("data_err_o", data_err_o, data_q[0].err);
        if (data_q[0].rd) begin
          check_word("data_rdata_o", data_rdata_o, data_q[0].rdata);
        end
        void'(data_q.pop_front());
      end else begin
        check_bit("data_rvalid_o", data_rvalid_o, 1'b0);
      end
      if (instr_q.size() > 0 && instr_q[0].due == cycle) begin
        check_bit("instr_rvalid_o", instr_rvalid_o, 1'b1);
        check_line("instr_rdata_o", instr_rdata_o, instr_q[0].line);
        void'(instr_q.pop_front());
      end else begin
        check_bit("instr_rvalid_o", instr_rvalid_o, 1'b0);
      end
    end
  end

  initial begin
    int n;
    int wr_edge;
    int ack_edge;
    int at;
    void'($urandom(32'hffbbc58b));
    rst_ni = 1'b0;
    instr_req_i = 1'b0;
    instr_addr_i = '0;
    data_req_i = 1'b0;
    data_we_i = 1'b0;
    data_addr_i = '0;
    data_wdata_i = '0;
    data_be_i = '0;
    irq_id_i = '0;
    irq_ack_i = 1'b0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    go_idle(2);

    // fill a region, patch random bytes, then read it back to back
    for (int i = 0; i < 32; i++) begin
      bus_access(1'b1, region + word_t'(4 * i), $urandom(), 4'hf, '0);
    end
    for (int i = 0; i < 48; i++) begin
      bus_access(1'b1, region + word_t'(4 * $urandom_range(31)), $urandom(),
                 be_t'($urandom()), '0);
    end
    for (int i = 0; i < 32; i++) begin
      bus_access(1'b0, region + word_t'(4 * i), '0, 4'hf, expected_word(region + word_t'(4 * i)));
    end
    go_idle(1);
    for (int i = 0; i < 8; i++) begin
      fetch(ram_addr_width'(region + word_t'(16 * i)));
    end
    go_idle(1);

    bus_access(1'b1, addr_status, status_pass_code, 4'hf, '0);
    bus_access(1'b1, addr_status, status_fail_code, 4'hf, '0);
    bus_access(1'b1, addr_exit, $urandom(), 4'hf, '0);
    bus_access(1'b1, addr_print, $urandom(), 4'hf, '0);
    go_idle(1);

    // masked countdown with a readback one edge after the write
    bus_access(1'b1, addr_timer_mask, word_t'(1) << timer_irq_id, 4'hf, '0);
    n = 2 + int'($urandom_range(38));
    wr_edge = cycle + 1;
    bus_access(1'b1, addr_timer_cnt, word_t'(n), 4'hf, '0);
    go_idle(1);
    bus_access(1'b0, addr_timer_read, '0, 4'hf, expected_count(n, wr_edge, cycle));
    go_idle(0);
    wait_irq(1'b1, 60, at);
    check_word("irq_timer_o edge", word_t'(at), word_t'(irq_edge(n, wr_edge)));
    send_ack(5'd3);
    repeat (3) begin
      @(negedge clk_i);
      check_bit("irq_timer_o", irq_timer_o, 1'b1);
    end
    @(posedge clk_i);
    #2;
    ack_edge = cycle + 1;
    send_ack(irq_id_t'(timer_irq_id));
    wait_irq(1'b0, 4, at);
    check_word("irq_timer_o clear edge", word_t'(at), word_t'(ack_edge));

    // unmasked countdown runs out quietly
    bus_access(1'b1, addr_timer_mask, '0, 4'hf, '0);
    n = 2 + int'($urandom_range(38));
    wr_edge = cycle + 1;
    bus_access(1'b1, addr_timer_cnt, word_t'(n), 4'hf, '0);
    go_idle(0);
    repeat (n + 3) begin
      @(negedge clk_i);
      check_bit("irq_timer_o", irq_timer_o, 1'b0);
    end
    @(posedge clk_i);
    #2;
    bus_access(1'b0, addr_timer_read, '0, 4'hf, expected_count(n, wr_edge, cycle));

    bus_access(1'b0, 32'h3000_0000, '0, 4'hf, '0);
    bus_access(1'b1, 32'h3000_0008, $urandom(), 4'hf, '0);
    go_idle(0);

    n = 0;
    while (data_q.size() > 0 || instr_q.size() > 0) begin
      if (n == 10) begin
        timed_out("the last responses");
      end
      @(posedge clk_i);
      #2;
      n++;
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== verilog/mm_ram.sv ====
`timescale 1ns/100ps

module mm_ram #(
  parameter int unsigned ram_addr_width = 16,
  parameter int unsigned instr_width = 128
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  logic                       instr_req_i,
  input  logic [ram_addr_width-1:0]  instr_addr_i,
  output logic [instr_width-1:0]     instr_rdata_o,
  output logic                       instr_rvalid_o,
  output logic                       instr_gnt_o,

  input  logic                       data_req_i,
  input  logic                       data_we_i,
  input  mm_ram_pkg::word_t          data_addr_i,
  input  mm_ram_pkg::word_t          data_wdata_i,
  input  mm_ram_pkg::be_t            data_be_i,
  output mm_ram_pkg::word_t          data_rdata_o,
  output logic                       data_rvalid_o,
  output logic                       data_gnt_o,
  output logic                       data_err_o,

  input  mm_ram_pkg::irq_id_t        irq_id_i,
  input  logic                       irq_ack_i,
  output logic                       irq_timer_o,

  output logic                       print_valid_o,
  output mm_ram_pkg::word_t          print_data_o,
  output logic                       tests_passed_o,
  output logic                       tests_failed_o,
  output logic                       exit_valid_o,
  output mm_ram_pkg::word_t          exit_value_o
);
  import mm_ram_pkg::*;

  ram_req_t                  ram_req;
  logic                      ram_instr_en;
  logic [ram_addr_width-1:0] ram_instr_addr;
  word_t                     ram_rdata;
  timer_cmd_t                timer_cmd;
  word_t                     timer_cnt;

  // address decode, grants and response mux
  mm_bus_ctrl #(
    .ram_addr_width(ram_addr_width)
  ) u_bus_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .instr_req_i     (instr_req_i),
    .instr_addr_i    (instr_addr_i),
    .instr_rvalid_o  (instr_rvalid_o),
    .instr_gnt_o     (instr_gnt_o),
    .data_req_i      (data_req_i),
    .data_we_i       (data_we_i),
    .data_addr_i     (data_addr_i),
    .data_wdata_i    (data_wdata_i),
    .data_be_i       (data_be_i),
    .data_rdata_o    (data_rdata_o),
    .data_rvalid_o   (data_rvalid_o),
    .data_gnt_o      (data_gnt_o),
    .data_err_o      (data_err_o),
    .ram_req_o       (ram_req),
    .ram_instr_en_o  (ram_instr_en),
    .ram_instr_addr_o(ram_instr_addr),
    .ram_rdata_i     (ram_rdata),
    .timer_cmd_o     (timer_cmd),
    .timer_cnt_i     (timer_cnt),
    .print_valid_o   (print_valid_o),
    .print_data_o    (print_data_o),
    .tests_passed_o  (tests_passed_o),
    .tests_failed_o  (tests_failed_o),
    .exit_valid_o    (exit_valid_o),
    .exit_value_o    (exit_value_o)
  );

  dp_ram #(
    .ram_addr_width(ram_addr_width),
    .instr_width   (instr_width)
  ) u_ram (
    .clk_i        (clk_i),
    .instr_en_i   (ram_instr_en),
    .instr_addr_i (ram_instr_addr),
    .instr_rdata_o(instr_rdata_o),
    .data_req_i   (ram_req),
    .data_rdata_o (ram_rdata)
  );

  mm_timer u_timer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cmd_i    (timer_cmd),
    .irq_id_i (irq_id_i),
    .irq_ack_i(irq_ack_i),
    .cnt_o    (timer_cnt),
    .irq_o    (irq_timer_o)
  );

endmodule

// ==== verilog/mm_bus_ctrl.sv ====
`timescale 1ns/100ps

module mm_bus_ctrl #(
  parameter int unsigned ram_addr_width = 16
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      instr_req_i,
  input  logic [ram_addr_width-1:0] instr_addr_i,
  output logic                      instr_rvalid_o,
  output logic                      instr_gnt_o,

  input  logic                      data_req_i,
  input  logic                      data_we_i,
  input  mm_ram_pkg::word_t         data_addr_i,
  input  mm_ram_pkg::word_t         data_wdata_i,
  input  mm_ram_pkg::be_t           data_be_i,
  output mm_ram_pkg::word_t         data_rdata_o,
  output logic                      data_rvalid_o,
  output logic                      data_gnt_o,
  output logic                      data_err_o,

  output mm_ram_pkg::ram_req_t      ram_req_o,
  output logic                      ram_instr_en_o,
  output logic [ram_addr_width-1:0] ram_instr_addr_o,
  input  mm_ram_pkg::word_t         ram_rdata_i,

  output mm_ram_pkg::timer_cmd_t    timer_cmd_o,
  input  mm_ram_pkg::word_t         timer_cnt_i,

  output logic                      print_valid_o,
  output mm_ram_pkg::word_t         print_data_o,
  output logic                      tests_passed_o,
  output logic                      tests_failed_o,
  output logic                      exit_valid_o,
  output mm_ram_pkg::word_t         exit_value_o
);
  import mm_ram_pkg::*;

  logic      in_ram;
  logic      wr;
  logic      rd;
  logic      wr_mapped;
  read_src_t read_src_d;
  read_src_t read_src_q;
  logic      data_rvalid_q;
  logic      instr_rvalid_q;
  word_t     cnt_rdata_q;

  // no stalls, every request is granted at once
  assign instr_gnt_o = instr_req_i;
  assign data_gnt_o = data_req_i;
  assign ram_instr_en_o = instr_req_i;
  assign ram_instr_addr_o = instr_addr_i;

  assign in_ram = (data_addr_i >> ram_addr_width) == '0;
  assign wr = data_req_i & data_we_i;
  assign rd = data_req_i & ~data_we_i;

  assign wr_mapped = data_addr_i == addr_print || data_addr_i == addr_status ||
                     data_addr_i == addr_exit || data_addr_i == addr_timer_mask ||
                     data_addr_i == addr_timer_cnt;

  always_comb begin
    ram_req_o.req = data_req_i & in_ram;
    ram_req_o.we = data_we_i;
    ram_req_o.be = data_be_i;
    ram_req_o.wdata = data_wdata_i;
    ram_req_o.addr = data_addr_i;

    timer_cmd_o.mask_we = wr && data_addr_i == addr_timer_mask;
    timer_cmd_o.cnt_we = wr && data_addr_i == addr_timer_cnt;
    timer_cmd_o.wdata = data_wdata_i;

    // strobes follow the write being presented
    print_valid_o = wr && data_addr_i == addr_print;
    print_data_o = print_valid_o ? data_wdata_i : '0;
    tests_passed_o = wr && data_addr_i == addr_status && data_wdata_i == status_pass_code;
    tests_failed_o = wr && data_addr_i == addr_status && data_wdata_i == status_fail_code;
    exit_valid_o = wr && data_addr_i == addr_exit;
    exit_value_o = exit_valid_o ? data_wdata_i : '0;

    read_src_d = rd_none;
    if (rd) begin
      if (in_ram) begin
        read_src_d = rd_ram;
      end else if (data_addr_i == addr_timer_read) begin
        read_src_d = rd_timer;
      end else begin
        read_src_d = rd_err;
      end
    end else if (wr && !in_ram && !wr_mapped) begin
      read_src_d = rd_err;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_src_q <= rd_none;
      data_rvalid_q <= 1'b0;
      instr_rvalid_q <= 1'b0;
    end else begin
      read_src_q <= read_src_d;
      data_rvalid_q <= data_req_i;
      instr_rvalid_q <= instr_req_i;
    end
  end

  // count as seen in the request cycle, like the RAM word
  always_ff @(posedge clk_i) begin
    if (read_src_d == rd_timer) begin
      cnt_rdata_q <= timer_cnt_i;
    end
  end

  always_comb begin
    unique case (read_src_q)
      rd_ram:   data_rdata_o = ram_rdata_i;
      rd_timer: data_rdata_o = cnt_rdata_q;
      default:  data_rdata_o = '0;
    endcase
  end

  assign data_rvalid_o = data_rvalid_q;
  assign instr_rvalid_o = instr_rvalid_q;
  assign data_err_o = read_src_q == rd_err;

  status_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(tests_passed_o && tests_failed_o));

  // one response per request, one cycle later
  rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rvalid_o |-> $past(data_req_i));

endmodule

// ==== verilog/mm_timer.sv ====
`timescale 1ns/100ps

module mm_timer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mm_ram_pkg::timer_cmd_t cmd_i,
  input  mm_ram_pkg::irq_id_t    irq_id_i,
  input  logic                   irq_ack_i,
  output mm_ram_pkg::word_t      cnt_o,
  output logic                   irq_o
);
  import mm_ram_pkg::*;

  word_t mask_q;
  word_t cnt_q;
  logic  irq_q;
  logic  cmd_write;
  logic  expire;

  assign cmd_write = cmd_i.mask_we | cmd_i.cnt_we;
  // count reaches zero on this edge
  assign expire = !cmd_write && cnt_q == 32'd1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '0;
      cnt_q <= '0;
      irq_q <= 1'b0;
    end else begin
      if (cmd_i.mask_we) begin
        mask_q <= cmd_i.wdata;
      end

      if (cmd_i.cnt_we) begin
        cnt_q <= cmd_i.wdata;
      end else if (!cmd_write && cnt_q != '0) begin
        cnt_q <= cnt_q - 32'd1;
      end

      // acknowledge wins over a new expiry
      if (irq_ack_i && irq_id_i == irq_id_t'(timer_irq_id)) begin
        irq_q <= 1'b0;
      end else if (expire && mask_q[timer_irq_id]) begin
        irq_q <= 1'b1;
      end
    end
  end

  assign cnt_o = cnt_q;
  assign irq_o = irq_q;

  irq_needs_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(irq_o) |-> $past(mask_q[timer_irq_id]));

endmodule

// ==== dp_ram/dp_ram.sv ====
`timescale 1ns/100ps

module dp_ram #(
  parameter int unsigned ram_addr_width = 16,
  parameter int unsigned instr_width = 128
) (
  input  logic                      clk_i,

  input  logic                      instr_en_i,
  input  logic [ram_addr_width-1:0] instr_addr_i,
  output logic [instr_width-1:0]    instr_rdata_o,

  input  mm_ram_pkg::ram_req_t      data_req_i,
  output mm_ram_pkg::word_t         data_rdata_o
);

  localparam int unsigned line_bytes = instr_width / 8;

  logic [7:0]                mem [2**ram_addr_width];
  logic [ram_addr_width-1:0] instr_base;
  logic [ram_addr_width-1:0] data_base;

  // both ports work on word aligned addresses
  assign instr_base = {instr_addr_i[ram_addr_width-1:2], 2'b00};
  assign data_base = {data_req_i.addr[ram_addr_width-1:2], 2'b00};

  // port A, lowest byte address lands in the lowest bits
  always_ff @(posedge clk_i) begin
    if (instr_en_i) begin
      for (int i = 0; i < line_bytes; i++) begin
        instr_rdata_o[8*i +: 8] <= mem[instr_base + ram_addr_width'(i)];
      end
    end
  end

  // port B, byte enabled write or one word read
  always_ff @(posedge clk_i) begin
    if (data_req_i.req) begin
      if (data_req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (data_req_i.be[b]) begin
            mem[data_base + ram_addr_width'(b)] <= data_req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        for (int b = 0; b < 4; b++) begin
          data_rdata_o[8*b +: 8] <= mem[data_base + ram_addr_width'(b)];
        end
      end
    end
  end

  // decode upstream must keep peripheral traffic off the RAM
  data_addr_in_range: assert property (@(posedge clk_i)
    data_req_i.req |-> (data_req_i.addr >> ram_addr_width) == '0);

  instr_line_in_range: assert property (@(posedge clk_i)
    instr_en_i |-> 33'(instr_base) + 33'(line_bytes) <= 33'(2**ram_addr_width));

endmodule

// ==== common/mm_ram_pkg.sv ====
package mm_ram_pkg;

  // bus widths
  typedef logic [31:0] word_t;
  typedef logic [3:0] be_t;
  typedef logic [4:0] irq_id_t;

  // mask bit and acknowledge id of the timer interrupt
  localparam int timer_irq_id = 7;

  // pseudo peripheral address map
  localparam word_t addr_print = 32'h1000_0000;
  localparam word_t addr_status = 32'h2000_0000;
  localparam word_t addr_exit = 32'h2000_0004;
  localparam word_t addr_timer_mask = 32'h1500_0000;
  localparam word_t addr_timer_cnt = 32'h1500_0004;
  localparam word_t addr_timer_read = 32'h1500_1000;

  // values written to the status address
  localparam word_t status_pass_code = 32'd123456789;
  localparam word_t status_fail_code = 32'd1;

  // data port request into the RAM, addr is the full byte address
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    word_t wdata;
    word_t addr;
  } ram_req_t;

  // register writes into the timer
  typedef struct packed {
    logic  mask_we;
    logic  cnt_we;
    word_t wdata;
  } timer_cmd_t;

  // source of the data response in flight
  typedef enum logic [1:0] {
    rd_none,
    rd_ram,
    rd_timer,
    rd_err
  } read_src_t;

endpackage
